//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = tb_core
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/core_ctrl_pkg.sv
// Internal control encodings
// ALU operation select
// Operand source selects for both ALU inputs
// Shift amount width and type
package core_ctrl_pkg;

    localparam int SHAMT_W = 5;

    typedef logic [SHAMT_W-1:0] shamt_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // ZERO lets LUI pass the immediate through the adder
    typedef enum logic [1:0] {
        OP1_RS1  = 2'd0,
        OP1_PC   = 2'd1,
        OP1_ZERO = 2'd2
    } op1_src_e;

    // FOUR builds the link value
    typedef enum logic [1:0] {
        OP2_RS2  = 2'd0,
        OP2_IMM  = 2'd1,
        OP2_FOUR = 2'd2
    } op2_src_e;

endpackage

//--- common/pipe_ifs.sv
// Stage-to-stage interfaces
// rf_read_if   two combinational register file reads
// dec_exe_if   decoded instruction into execute
// exe_res_if   registered ALU result into writeback
`timescale 1ns/1ns

interface rf_read_if;
    rv_isa_pkg::reg_idx_t rs1_idx;
    rv_isa_pkg::reg_idx_t rs2_idx;
    rv_isa_pkg::word_t    rs1_val;
    rv_isa_pkg::word_t    rs2_val;

    modport reader (output rs1_idx, output rs2_idx, input rs1_val, input rs2_val);
    modport file   (input rs1_idx, input rs2_idx, output rs1_val, output rs2_val);
endinterface

interface dec_exe_if;
    logic                     valid;
    rv_isa_pkg::word_t        pc;
    rv_isa_pkg::reg_idx_t     rd_idx;
    logic                     rd_we;
    logic                     illegal;
    rv_isa_pkg::word_t        rs1_val;
    rv_isa_pkg::word_t        rs2_val;
    rv_isa_pkg::word_t        imm;
    core_ctrl_pkg::alu_op_e   alu_op;
    core_ctrl_pkg::op1_src_e  op1_src;
    core_ctrl_pkg::op2_src_e  op2_src;

    modport decode (
        output valid, pc, rd_idx, rd_we, illegal, rs1_val, rs2_val,
        output imm, alu_op, op1_src, op2_src
    );
    modport execute (
        input valid, pc, rd_idx, rd_we, illegal, rs1_val, rs2_val,
        input imm, alu_op, op1_src, op2_src
    );
endinterface

interface exe_res_if;
    logic                 valid;
    logic                 illegal;
    logic                 we;
    rv_isa_pkg::reg_idx_t rd_idx;
    rv_isa_pkg::word_t    data;

    modport execute (output valid, illegal, we, rd_idx, data);
    modport result  (input valid, illegal, we, rd_idx, data);
endinterface

//--- common/rv_isa_pkg.sv
// RV32I encoding definitions
// Data, instruction and register index types
// Instruction field types
// Major opcodes (instruction bits 6..2)
// Immediate formats kept by the decode stage
package rv_isa_pkg;

    localparam int XLEN           = 32;
    localparam int REG_IDX_W      = 5;
    localparam int OPCODE_W       = 5;
    localparam int NUM_REGS       = 32;
    // Link offset for JAL and JALR
    localparam int PC_STEP        = 4;
    // funct7 bit that turns ADD into SUB and SRL into SRA
    localparam int FUNCT7_ALT_BIT = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [31:0]          instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [6:0]           funct7_t;

    // Only OP, OP_IMM, LUI, AUIPC, JAL and JALR are executed
    // The rest are named so they read clearly as illegal
    typedef enum logic [OPCODE_W-1:0] {
        OPCODE_LOAD     = 5'b00000,
        OPCODE_MISC_MEM = 5'b00011,
        OPCODE_OP_IMM   = 5'b00100,
        OPCODE_AUIPC    = 5'b00101,
        OPCODE_STORE    = 5'b01000,
        OPCODE_AMO      = 5'b01011,
        OPCODE_OP       = 5'b01100,
        OPCODE_LUI      = 5'b01101,
        OPCODE_BRANCH   = 5'b11000,
        OPCODE_JALR     = 5'b11001,
        OPCODE_JAL      = 5'b11011,
        OPCODE_SYSTEM   = 5'b11100
    } opcode_e;

    // BAD marks an unsupported opcode
    typedef enum logic [2:0] {
        FMT_BAD = 3'd0,
        FMT_R   = 3'd1,
        FMT_I   = 3'd2,
        FMT_U   = 3'd3,
        FMT_J   = 3'd4
    } imm_format_e;

endpackage

//--- decode/instr_decode.sv
// Decode stage
// Input flops with stall hold and flush gating
// Opcode to immediate format classification
// I, U and J immediate generation
// ALU and operand control, rd write enable, illegal detect
`timescale 1ns/1ns

module instr_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               in_valid,
    input  rv_isa_pkg::instr_t in_instr,
    input  rv_isa_pkg::word_t  in_pc,
    rf_read_if.reader          rf,
    dec_exe_if.decode          dx
);

    logic                     valid_q;
    rv_isa_pkg::instr_t       instr_q;
    rv_isa_pkg::word_t        pc_q;
    rv_isa_pkg::opcode_e      opcode;
    rv_isa_pkg::imm_format_e  fmt;
    rv_isa_pkg::funct3_t      funct3;
    rv_isa_pkg::funct7_t      funct7;
    rv_isa_pkg::reg_idx_t     rd_idx;
    rv_isa_pkg::word_t        imm;
    core_ctrl_pkg::alu_op_e   alu_op;
    core_ctrl_pkg::op1_src_e  op1_src;
    core_ctrl_pkg::op2_src_e  op2_src;
    logic                     illegal;

    // Shared funct3 map for OP and OP_IMM
    // Immediate forms have no SUB, bit 30 is part of the immediate there
    function automatic core_ctrl_pkg::alu_op_e funct3_to_alu(
        input rv_isa_pkg::funct3_t f3,
        input logic                alt,
        input logic                reg_form
    );
        core_ctrl_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (alt && reg_form) ? core_ctrl_pkg::ALU_SUB : core_ctrl_pkg::ALU_ADD;
            3'b001:  op = core_ctrl_pkg::ALU_SLL;
            3'b010:  op = core_ctrl_pkg::ALU_SLT;
            3'b011:  op = core_ctrl_pkg::ALU_SLTU;
            3'b100:  op = core_ctrl_pkg::ALU_XOR;
            3'b101:  op = alt ? core_ctrl_pkg::ALU_SRA : core_ctrl_pkg::ALU_SRL;
            3'b110:  op = core_ctrl_pkg::ALU_OR;
            default: op = core_ctrl_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // Valid cleared on reset, held on stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            instr_q <= in_instr;
            pc_q    <= in_pc;
        end
    end

    // Field slicing
    assign opcode = rv_isa_pkg::opcode_e'(instr_q[6:2]);
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];
    assign rd_idx = instr_q[11:7];

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPCODE_OP:    fmt = rv_isa_pkg::FMT_R;
            rv_isa_pkg::OPCODE_OP_IMM,
            rv_isa_pkg::OPCODE_JALR:  fmt = rv_isa_pkg::FMT_I;
            rv_isa_pkg::OPCODE_LUI,
            rv_isa_pkg::OPCODE_AUIPC: fmt = rv_isa_pkg::FMT_U;
            rv_isa_pkg::OPCODE_JAL:   fmt = rv_isa_pkg::FMT_J;
            default:                  fmt = rv_isa_pkg::FMT_BAD;
        endcase
    end

    // Sign extended from bit 31 in every format
    always_comb begin
        case (fmt)
            rv_isa_pkg::FMT_I: imm = {{20{instr_q[31]}}, instr_q[31:20]};
            rv_isa_pkg::FMT_U: imm = {instr_q[31:12], 12'b0};
            rv_isa_pkg::FMT_J: imm = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20],
                                      instr_q[30:21], 1'b0};
            default:           imm = '0;
        endcase
    end

    // Compressed encodings are not supported
    assign illegal = (fmt == rv_isa_pkg::FMT_BAD) || (instr_q[1:0] != 2'b11);

    always_comb begin
        alu_op    = core_ctrl_pkg::ALU_ADD;
        op1_src   = core_ctrl_pkg::OP1_RS1;
        op2_src   = core_ctrl_pkg::OP2_RS2;
        case (opcode)
            rv_isa_pkg::OPCODE_OP: begin
                alu_op = funct3_to_alu(funct3, funct7[rv_isa_pkg::FUNCT7_ALT_BIT], 1'b1);
            end
            rv_isa_pkg::OPCODE_OP_IMM: begin
                alu_op  = funct3_to_alu(funct3, funct7[rv_isa_pkg::FUNCT7_ALT_BIT], 1'b0);
                op2_src = core_ctrl_pkg::OP2_IMM;
            end
            rv_isa_pkg::OPCODE_LUI: begin
                op1_src = core_ctrl_pkg::OP1_ZERO;
                op2_src = core_ctrl_pkg::OP2_IMM;
            end
            rv_isa_pkg::OPCODE_AUIPC: begin
                op1_src = core_ctrl_pkg::OP1_PC;
                op2_src = core_ctrl_pkg::OP2_IMM;
            end
            // Link value only, no redirect
            rv_isa_pkg::OPCODE_JAL,
            rv_isa_pkg::OPCODE_JALR: begin
                op1_src = core_ctrl_pkg::OP1_PC;
                op2_src = core_ctrl_pkg::OP2_FOUR;
            end
            // Other opcodes keep the defaults and are flagged illegal
            default: ;
        endcase
    end

    // Register reads happen in the decode cycle
    assign rf.rs1_idx = instr_q[19:15];
    assign rf.rs2_idx = instr_q[24:20];

    assign dx.valid   = valid_q && !flush && !stall;
    assign dx.pc      = pc_q;
    assign dx.rd_idx  = rd_idx;
    // x0 never written
    assign dx.rd_we   = !illegal && (rd_idx != '0);
    assign dx.illegal = illegal;
    assign dx.rs1_val = rf.rs1_val;
    assign dx.rs2_val = rf.rs2_val;
    assign dx.imm     = imm;
    assign dx.alu_op  = alu_op;
    assign dx.op1_src = op1_src;
    assign dx.op2_src = op2_src;

endmodule

//--- execute/alu_execute.sv
// Execute stage
// Operand muxes for both ALU inputs
// Integer ALU
// Execute pipeline register, held on stall
`timescale 1ns/1ns

module alu_execute (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    dec_exe_if.execute  dx,
    exe_res_if.execute  xr
);

    rv_isa_pkg::word_t     op1;
    rv_isa_pkg::word_t     op2;
    rv_isa_pkg::word_t     result;
    core_ctrl_pkg::shamt_t shamt;

    logic                  valid_q;
    logic                  illegal_q;
    logic                  we_q;
    rv_isa_pkg::reg_idx_t  rd_idx_q;
    rv_isa_pkg::word_t     data_q;

    always_comb begin
        case (dx.op1_src)
            core_ctrl_pkg::OP1_RS1: op1 = dx.rs1_val;
            core_ctrl_pkg::OP1_PC:  op1 = dx.pc;
            default:                op1 = '0;
        endcase
    end

    always_comb begin
        case (dx.op2_src)
            core_ctrl_pkg::OP2_RS2:  op2 = dx.rs2_val;
            core_ctrl_pkg::OP2_IMM:  op2 = dx.imm;
            default:                 op2 = rv_isa_pkg::word_t'(rv_isa_pkg::PC_STEP);
        endcase
    end

    // Shifts use the low bits only
    assign shamt = op2[core_ctrl_pkg::SHAMT_W-1:0];

    always_comb begin
        case (dx.alu_op)
            core_ctrl_pkg::ALU_ADD:  result = op1 + op2;
            core_ctrl_pkg::ALU_SUB:  result = op1 - op2;
            core_ctrl_pkg::ALU_SLL:  result = op1 << shamt;
            core_ctrl_pkg::ALU_SLT:  result = {{(rv_isa_pkg::XLEN-1){1'b0}},
                                               $signed(op1) < $signed(op2)};
            core_ctrl_pkg::ALU_SLTU: result = {{(rv_isa_pkg::XLEN-1){1'b0}}, op1 < op2};
            core_ctrl_pkg::ALU_XOR:  result = op1 ^ op2;
            core_ctrl_pkg::ALU_SRL:  result = op1 >> shamt;
            // Arithmetic shift keeps the sign
            core_ctrl_pkg::ALU_SRA:  result = $signed(op1) >>> shamt;
            core_ctrl_pkg::ALU_OR:   result = op1 | op2;
            core_ctrl_pkg::ALU_AND:  result = op1 & op2;
            default:                 result = '0;
        endcase
    end

    // Control bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
            we_q      <= 1'b0;
        end else if (!stall) begin
            valid_q   <= dx.valid;
            illegal_q <= dx.illegal;
            we_q      <= dx.rd_we;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            rd_idx_q <= dx.rd_idx;
            data_q   <= result;
        end
    end

    // Held item must not retire while stalled
    assign xr.valid   = valid_q && !stall;
    assign xr.illegal = illegal_q;
    assign xr.we      = we_q;
    assign xr.rd_idx  = rd_idx_q;
    assign xr.data    = data_q;

endmodule

//--- logic/core_pipe_top.sv
// Three-stage integer pipeline top level
// Decode, execute and result stages
// Stage interfaces and plain external ports
`timescale 1ns/1ns

module core_pipe_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  rv_isa_pkg::instr_t    in_instr,
    input  rv_isa_pkg::word_t     in_pc,
    input  logic                  stall,
    input  logic                  flush,
    output logic                  out_valid,
    output logic                  out_illegal,
    output logic                  out_we,
    output rv_isa_pkg::reg_idx_t  out_rd_idx,
    output rv_isa_pkg::word_t     out_data
);

    rf_read_if rf_bus ();
    dec_exe_if dx_bus ();
    exe_res_if xr_bus ();

    // Decode also drives the register reads
    instr_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .rf       (rf_bus.reader),
        .dx       (dx_bus.decode)
    );

    alu_execute u_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .dx    (dx_bus.execute),
        .xr    (xr_bus.execute)
    );

    // Holds the register file
    result_writeback u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .xr          (xr_bus.result),
        .rf          (rf_bus.file),
        .out_valid   (out_valid),
        .out_illegal (out_illegal),
        .out_we      (out_we),
        .out_rd_idx  (out_rd_idx),
        .out_data    (out_data)
    );

endmodule

//--- logic/result_writeback.sv
// Result stage
// Register file with two combinational reads
// Writeback of valid, writing items
// Registered result outputs
`timescale 1ns/1ns

module result_writeback (
    input  logic                  clk,
    input  logic                  rst_n,
    exe_res_if.result             xr,
    rf_read_if.file               rf,
    output logic                  out_valid,
    output logic                  out_illegal,
    output logic                  out_we,
    output rv_isa_pkg::reg_idx_t  out_rd_idx,
    output rv_isa_pkg::word_t     out_data
);

    rv_isa_pkg::word_t regs [rv_isa_pkg::NUM_REGS];

    // Whole file cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (xr.valid && xr.we) begin
            regs[xr.rd_idx] <= xr.data;
        end
    end

    // No bypass, a same-edge write shows next cycle
    // x0 forced to zero
    assign rf.rs1_val = (rf.rs1_idx == '0) ? '0 : regs[rf.rs1_idx];
    assign rf.rs2_val = (rf.rs2_idx == '0) ? '0 : regs[rf.rs2_idx];

    // Flags qualified by valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            out_illegal <= 1'b0;
            out_we      <= 1'b0;
        end else begin
            out_valid   <= xr.valid;
            out_illegal <= xr.valid && xr.illegal;
            out_we      <= xr.valid && xr.we;
        end
    end

    always_ff @(posedge clk) begin
        out_rd_idx <= xr.rd_idx;
        out_data   <= xr.data;
    end

endmodule

//--- sim.f
common/rv_isa_pkg.sv
common/core_ctrl_pkg.sv
common/pipe_ifs.sv
decode/instr_decode.sv
execute/alu_execute.sv
logic/result_writeback.sv
logic/core_pipe_top.sv
tb/tb_core.sv

//--- tb/tb_core.sv
// Directed testbench for the three-stage integer pipeline
// Register model with the one-slot hazard rule
// Expected result queue with cycle-exact arrival times
// Tests for reset, ALU ops, upper/jump ops, x0, illegal, hazards, stall and flush
`timescale 1ns/1ns

module tb_core;

    typedef struct packed {
        int          exp_cyc;
        int          iss_cyc;
        logic [4:0]  rd;
        logic        we;
        logic        ill;
        logic        chk;
        logic [31:0] data;
    } exp_t;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    rv_isa_pkg::instr_t   in_instr;
    rv_isa_pkg::word_t    in_pc;
    logic                 stall;
    logic                 flush;
    logic                 out_valid;
    logic                 out_illegal;
    logic                 out_we;
    rv_isa_pkg::reg_idx_t out_rd_idx;
    rv_isa_pkg::word_t    out_data;

    // Model state
    rv_isa_pkg::word_t mregs [32];
    logic              pend_v;
    logic [4:0]        pend_rd;
    rv_isa_pkg::word_t pend_val;
    exp_t              expq [$];
    rv_isa_pkg::word_t pc;
    int                cyc;
    int                errors;
    int                checks;
    logic              checking;

    core_pipe_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_pc       (in_pc),
        .stall       (stall),
        .flush       (flush),
        .out_valid   (out_valid),
        .out_illegal (out_illegal),
        .out_we      (out_we),
        .out_rd_idx  (out_rd_idx),
        .out_data    (out_data)
    );

    always #5 clk = ~clk;

    function automatic rv_isa_pkg::word_t rd_reg(input logic [4:0] r);
        return (r == 5'd0) ? '0 : mregs[r];
    endfunction

    function automatic rv_isa_pkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Reference ALU from the RV32I rules
    function automatic rv_isa_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                                  input rv_isa_pkg::word_t a,
                                                  input rv_isa_pkg::word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? rv_isa_pkg::word_t'($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Instruction encoders
    function automatic rv_isa_pkg::instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3,
                                                 input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic rv_isa_pkg::instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_isa_pkg::instr_t enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6F};
    endfunction

    // One clock of stimulus, driven on the rising edge
    task automatic step(input logic v, input rv_isa_pkg::instr_t ins,
                        input logic st, input logic fl);
        @(posedge clk);
        cyc = cyc + 1;
        in_valid <= v;
        in_instr <= ins;
        in_pc    <= pc;
        stall    <= st;
        flush    <= fl;
    endtask

    task automatic commit_pending();
        if (pend_v && pend_rd != 5'd0) begin
            mregs[pend_rd] = pend_val;
        end
        pend_v = 1'b0;
    endtask

    // Previous write stays pending so the next slot reads the old value
    task automatic issue(input rv_isa_pkg::instr_t ins, input logic [4:0] rd, input logic we,
                         input logic ill, input logic chk, input rv_isa_pkg::word_t data);
        exp_t e;
        step(1'b1, ins, 1'b0, 1'b0);
        e.exp_cyc = cyc + 3;
        e.iss_cyc = cyc;
        e.rd      = rd;
        e.we      = we;
        e.ill     = ill;
        e.chk     = chk;
        e.data    = data;
        expq.push_back(e);
        commit_pending();
        pend_v   = we;
        pend_rd  = rd;
        pend_val = data;
        pc       = pc + 32'd4;
    endtask

    task automatic idle();
        step(1'b0, '0, 1'b0, 1'b0);
        commit_pending();
    endtask

    // Items not yet in the output registers slip by one per stall cycle
    task automatic stall_cycles(input int k);
        for (int n = 0; n < k; n++) begin
            step(1'b0, '0, 1'b1, 1'b0);
            for (int i = 0; i < expq.size(); i++) begin
                if (expq[i].exp_cyc > cyc) begin
                    expq[i].exp_cyc = expq[i].exp_cyc + 1;
                end
            end
        end
    endtask

    // Drops whatever was issued in the previous slot
    task automatic flush_decode();
        int idx;
        idx = -1;
        step(1'b0, '0, 1'b0, 1'b1);
        for (int i = 0; i < expq.size(); i++) begin
            if (expq[i].iss_cyc == cyc - 1) begin
                idx = i;
            end
        end
        if (idx >= 0) begin
            expq.delete(idx);
        end
        pend_v = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (expq.size() > 0 && n < 40) begin
            idle();
            n++;
        end
        if (expq.size() > 0) begin
            $display("Timeout: %0d expected results never appeared", expq.size());
            errors++;
            expq.delete();
        end
    endtask

    // Output monitor, sampled on the falling edge
    always @(negedge clk) begin
        exp_t e;
        if (checking) begin
            if (out_valid) begin
                if (expq.size() == 0) begin
                    $display("FAIL %0t: unexpected result for x%0d", $time, out_rd_idx);
                    errors++;
                end else begin
                    e = expq.pop_front();
                    checks++;
                    if (e.exp_cyc != cyc) begin
                        $display("FAIL %0t: result for x%0d at cycle %0d, expected %0d",
                                 $time, e.rd, cyc, e.exp_cyc);
                        errors++;
                    end
                    if (out_rd_idx != e.rd) begin
                        $display("FAIL %0t: rd x%0d, expected x%0d", $time, out_rd_idx, e.rd);
                        errors++;
                    end
                    if (out_we != e.we || out_illegal != e.ill) begin
                        $display("FAIL %0t: we/illegal %b/%b, expected %b/%b", $time,
                                 out_we, out_illegal, e.we, e.ill);
                        errors++;
                    end
                    if (e.chk && out_data != e.data) begin
                        $display("FAIL %0t: x%0d data %h, expected %h", $time, e.rd,
                                 out_data, e.data);
                        errors++;
                    end
                end
            end else begin
                if (out_we || out_illegal) begin
                    $display("FAIL %0t: we or illegal high without valid", $time);
                    errors++;
                end
                if (expq.size() > 0 && expq[0].exp_cyc < cyc) begin
                    $display("FAIL %0t: result for x%0d missing", $time, expq[0].rd);
                    errors++;
                    e = expq.pop_front();
                end
            end
        end
    end

    task automatic reset_latency();
        rv_isa_pkg::word_t rnd;
        repeat (4) idle();
        rnd = $urandom();
        issue(enc_i(rnd[11:0], 5'd0, 3'd0, 5'd1, 7'h13), 5'd1, 1'b1, 1'b0, 1'b1,
              sext12(rnd[11:0]));
        drain();
    endtask

    task automatic arith_ops();
        rv_isa_pkg::word_t rnd;
        logic [11:0]       imm;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        for (int r = 1; r <= 4; r++) begin
            rnd = $urandom();
            issue(enc_i(rnd[11:0], 5'd0, 3'd0, 5'(r), 7'h13), 5'(r), 1'b1, 1'b0, 1'b1,
                  sext12(rnd[11:0]));
        end
        drain();
        // Register forms, both operand pairs
        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 0 || f == 5) begin
                    rs1 = (f % 2 == 0) ? 5'd1 : 5'd3;
                    rs2 = (f % 2 == 0) ? 5'd2 : 5'd4;
                    issue(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, 3'(f), 5'(10 + f + 2 * alt)),
                          5'(10 + f + 2 * alt), 1'b1, 1'b0, 1'b1,
                          alu_ref(3'(f), alt[0], rd_reg(rs1), rd_reg(rs2)));
                end
            end
        end
        // Immediate forms
        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 5) begin
                    rnd = $urandom();
                    imm = (f == 1 || f == 5) ? {1'b0, alt[0], 5'd0, rnd[4:0]} : rnd[11:0];
                    issue(enc_i(imm, 5'd3, 3'(f), 5'(20 + f + alt), 7'h13),
                          5'(20 + f + alt), 1'b1, 1'b0, 1'b1,
                          alu_ref(3'(f), alt[0] && f == 5, rd_reg(5'd3), sext12(imm)));
                end
            end
        end
        drain();
    endtask

    task automatic upper_jump_ops();
        rv_isa_pkg::word_t rnd;
        rnd = $urandom();
        pc  = {rnd[31:2], 2'b00};
        rnd = $urandom();
        issue({rnd[19:0], 5'd5, 7'h37}, 5'd5, 1'b1, 1'b0, 1'b1, {rnd[19:0], 12'd0});
        issue({rnd[31:12], 5'd6, 7'h17}, 5'd6, 1'b1, 1'b0, 1'b1, pc + {rnd[31:12], 12'd0});
        issue(enc_j(21'h00800, 5'd7), 5'd7, 1'b1, 1'b0, 1'b1, pc + 32'd4);
        issue(enc_i(12'd12, 5'd1, 3'd0, 5'd8, 7'h67), 5'd8, 1'b1, 1'b0, 1'b1, pc + 32'd4);
        drain();
    endtask

    task automatic x0_and_illegal();
        rv_isa_pkg::instr_t ins;
        issue(enc_i(12'd7, 5'd1, 3'd0, 5'd0, 7'h13), 5'd0, 1'b0, 1'b0, 1'b1,
              rd_reg(5'd1) + 32'd7);
        idle();
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9), 5'd9, 1'b1, 1'b0, 1'b1, 32'd0);
        // Store, SYSTEM and a non-32-bit encoding
        issue({7'd0, 5'd2, 5'd1, 3'b010, 5'd12, 7'h23}, 5'd12, 1'b0, 1'b1, 1'b0, '0);
        issue(32'h0000_0073, 5'd0, 1'b0, 1'b1, 1'b0, '0);
        ins = enc_i(12'd5, 5'd1, 3'd0, 5'd12, 7'h13);
        issue({ins[31:2], 2'b01}, 5'd12, 1'b0, 1'b1, 1'b0, '0);
        idle();
        issue(enc_r(7'h00, 5'd0, 5'd12, 3'd0, 5'd13), 5'd13, 1'b1, 1'b0, 1'b1, rd_reg(5'd12));
        drain();
    endtask

    task automatic hazard_timing();
        issue(enc_i(12'd111, 5'd0, 3'd0, 5'd15, 7'h13), 5'd15, 1'b1, 1'b0, 1'b1, 32'd111);
        drain();
        // Back to back consumer sees the old value
        issue(enc_i(12'd222, 5'd0, 3'd0, 5'd15, 7'h13), 5'd15, 1'b1, 1'b0, 1'b1, 32'd222);
        issue(enc_r(7'h00, 5'd0, 5'd15, 3'd0, 5'd16), 5'd16, 1'b1, 1'b0, 1'b1, 32'd111);
        drain();
        // One slot later the new value is visible
        issue(enc_i(12'd333, 5'd0, 3'd0, 5'd15, 7'h13), 5'd15, 1'b1, 1'b0, 1'b1, 32'd333);
        idle();
        issue(enc_r(7'h00, 5'd0, 5'd15, 3'd0, 5'd17), 5'd17, 1'b1, 1'b0, 1'b1, 32'd333);
        drain();
    endtask

    task automatic stall_and_flush();
        issue(enc_i(12'd41, 5'd0, 3'd0, 5'd20, 7'h13), 5'd20, 1'b1, 1'b0, 1'b1, 32'd41);
        stall_cycles(3);
        drain();
        issue(enc_i(12'd42, 5'd0, 3'd0, 5'd24, 7'h13), 5'd24, 1'b1, 1'b0, 1'b1, 32'd42);
        issue(enc_i(12'd43, 5'd0, 3'd0, 5'd25, 7'h13), 5'd25, 1'b1, 1'b0, 1'b1, 32'd43);
        stall_cycles(2);
        drain();
        // Flushed write to x21 must never land
        issue(enc_i(12'd99, 5'd0, 3'd0, 5'd21, 7'h13), 5'd21, 1'b1, 1'b0, 1'b1, 32'd99);
        flush_decode();
        issue(enc_i(12'd44, 5'd0, 3'd0, 5'd22, 7'h13), 5'd22, 1'b1, 1'b0, 1'b1, 32'd44);
        idle();
        issue(enc_r(7'h00, 5'd0, 5'd21, 3'd0, 5'd23), 5'd23, 1'b1, 1'b0, 1'b1, rd_reg(5'd21));
        drain();
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        in_pc     = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        cyc       = 0;
        errors    = 0;
        checks    = 0;
        checking  = 1'b0;
        pend_v    = 1'b0;
        pend_rd   = '0;
        pend_val  = '0;
        pc        = 32'h0000_0100;
        void'($urandom(81));
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n    <= 1'b1;
        checking = 1'b1;

        reset_latency();
        arith_ops();
        upper_jump_ops();
        x0_and_illegal();
        hazard_timing();
        stall_and_flush();
        repeat (4) idle();

        $display("Results checked: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
